// File: cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
    import eeg_cmd_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               cmd_vld,
    input  wire  [cmd_w-1:0]  cmd_dat,
    output logic              aram_idx_ld,
    output logic              wram_idx_ld,
    output logic              wram_sel_ld,
    output logic              oram_idx_ld,
    output logic              aram_win_ld,
    output logic              wram_win_ld,
    output logic              layer_ld,
    output logic              mult_ld,
    output logic              bias_ld,
    output logic              conv_ld,
    output logic              pool_ld,
    output logic [op_num-1:0] op_lvl,
    output logic              info_vld,
    output logic [op_num-1:0] info_cmd
);

    opcode_t           opcode;
    logic [op_num-1:0] op_nxt;

    assign opcode = opcode_t'(cmd_dat[fld_opcode_lo +: fld_opcode_w]);

    //======================================================================
    // Bank load strobes
    //======================================================================
    // Index loads
    assign aram_idx_ld = cmd_vld && (opcode == op_itoa || opcode == op_atow ||
                                     opcode == op_read);
    assign wram_idx_ld = cmd_vld && (opcode == op_atow || opcode == op_read);
    assign wram_sel_ld = cmd_vld && (opcode == op_itow);
    assign oram_idx_ld = cmd_vld && (opcode == op_read);

    // Window base and length, from a transfer or an info command
    assign aram_win_ld = cmd_vld && (opcode == op_itoa || opcode == op_inf_aram);
    assign wram_win_ld = cmd_vld && (opcode == op_itow || opcode == op_inf_wram);

    // Convolution and pooling banks
    assign layer_ld    = cmd_vld && (opcode == op_inf_conv);
    assign mult_ld     = cmd_vld && (opcode == op_inf_mult);
    assign bias_ld     = cmd_vld && (opcode == op_inf_bias);
    assign conv_ld     = cmd_vld && (opcode == op_conv);
    assign pool_ld     = cmd_vld && (opcode == op_pool);

    //======================================================================
    // Operation levels
    //======================================================================
    // Info and unused codes give all zero
    always_comb begin
        op_nxt = '0;
        case (opcode)
            op_itoa: op_nxt[0] = 1'b1;
            op_itow: op_nxt[1] = 1'b1;
            op_atow: op_nxt[2] = 1'b1;
            op_conv: op_nxt[3] = 1'b1;
            op_pool: op_nxt[4] = 1'b1;
            op_read: op_nxt[5] = 1'b1;
            default: op_nxt    = '0;
        endcase
    end

    // Level holds until the next valid command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_lvl <= '0;
        end else if (cmd_vld) begin
            op_lvl <= op_nxt;
        end
    end

    // One-cycle info pulse per accepted command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            info_vld <= 1'b0;
        end else begin
            info_vld <= cmd_vld;
        end
    end

    assign info_cmd = op_lvl;

endmodule

`default_nettype wire

// File: conv_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module conv_cfg_regs
    import eeg_cmd_pkg::*, eeg_cfg_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire  [cmd_w-1:0]      cmd_dat,
    input  wire                   layer_ld,
    input  wire                   mult_ld,
    input  wire                   bias_ld,
    input  wire                   conv_ld,
    output logic [conv_ch_w-1:0]  conv_ich,
    output logic [conv_ch_w-1:0]  conv_och,
    output logic [conv_len_w-1:0] conv_len,
    output logic [wram_add_w-1:0] mult_add,
    output logic [wram_add_w-1:0] bias_add,
    output logic [fac_w-1:0]      strd_fac,
    output logic [fac_w-1:0]      dila_fac,
    output logic [wei_w-1:0]      conv_wei,
    output logic                  resn_ena,
    output logic                  cpad_ena
);

    // Layer shape from INF_CONV
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conv_ich <= '0;
            conv_och <= '0;
            conv_len <= '0;
        end else if (layer_ld) begin
            conv_ich <= cmd_dat[fld_conv_ich_lo +: fld_conv_ich_w];
            conv_och <= cmd_dat[fld_conv_och_lo +: fld_conv_och_w];
            conv_len <= cmd_dat[fld_conv_len_lo +: fld_conv_len_w];
        end
    end

    //======================================================================
    // Coefficient base addresses in weight RAM
    //======================================================================
    // Multiplier and bias share one field position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mult_add <= '0;
        end else if (mult_ld) begin
            mult_add <= cmd_dat[fld_coef_add_lo +: fld_coef_add_w];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bias_add <= '0;
        end else if (bias_ld) begin
            bias_add <= cmd_dat[fld_coef_add_lo +: fld_coef_add_w];
        end
    end

    // Kernel settings, all from CONV
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strd_fac <= '0;
            dila_fac <= '0;
            conv_wei <= '0;
            resn_ena <= 1'b0;
            cpad_ena <= 1'b0;
        end else if (conv_ld) begin
            strd_fac <= cmd_dat[fld_strd_lo +: fld_strd_w];
            dila_fac <= cmd_dat[fld_dila_lo +: fld_dila_w];
            conv_wei <= cmd_dat[fld_wei_lo +: fld_wei_w];
            resn_ena <= cmd_dat[fld_resn_lo +: fld_resn_w];
            cpad_ena <= cmd_dat[fld_cpad_lo +: fld_cpad_w];
        end
    end

endmodule

`default_nettype wire

// File: eeg_cfg_pkg.sv
`default_nettype none

package eeg_cfg_pkg;

    //======================================================================
    // Configuration register widths
    //======================================================================

    // Bank index, one bit per bank
    localparam int bank_w     = 4;

    // RAM address widths, 4k activation and 8k weight words
    localparam int aram_add_w = 12;
    localparam int wram_add_w = 13;

    // Layer shape
    localparam int conv_ch_w  = 8;
    localparam int conv_len_w = 10;

    // Stride, dilation and pool factor, encoded as 1/2/4/8
    localparam int fac_w      = 2;

    // Up to 8 kernel taps
    localparam int wei_w      = 3;

    localparam int pool_len_w = 10;

endpackage

`default_nettype wire

// File: eeg_cmd_checker.sv
`timescale 1ns/1ps
`default_nettype none

module eeg_cmd_checker
    import eeg_cmd_pkg::*;
(
    input wire              clk,
    input wire              rst_n,
    input wire              cmd_vld,
    input wire              aram_win_ld,
    input wire              wram_win_ld,
    input wire [op_num-1:0] op_lvl,
    input wire              info_vld,
    input wire [op_num-1:0] info_cmd
);

    int fail_cnt = 0;

    //======================================================================
    // Decoder output rules
    //======================================================================
    // Info pulse trails each accepted command by one edge
    a_info_vld: assert property (@(posedge clk) disable iff (!rst_n)
        info_vld == $past(cmd_vld))
    else begin
        fail_cnt++;
        $error("info_vld does not follow cmd_vld of the previous cycle");
    end

    // At most one operation level at a time
    a_op_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(op_lvl))
    else begin
        fail_cnt++;
        $error("op_lvl has more than one bit set");
    end

    // Activation and weight windows never load together
    a_win_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(aram_win_ld && wram_win_ld))
    else begin
        fail_cnt++;
        $error("aram_win_ld and wram_win_ld are high together");
    end

    // Info command changes only with an info pulse
    a_info_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        !info_vld |-> $stable(info_cmd))
    else begin
        fail_cnt++;
        $error("info_cmd changed without an info pulse");
    end

endmodule

bind cmd_decoder eeg_cmd_checker u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_vld     (cmd_vld),
    .aram_win_ld (aram_win_ld),
    .wram_win_ld (wram_win_ld),
    .op_lvl      (op_lvl),
    .info_vld    (info_vld),
    .info_cmd    (info_cmd)
);

`default_nettype wire

// File: eeg_cmd_pkg.sv
`default_nettype none

package eeg_cmd_pkg;

    // Host command word
    localparam int cmd_w  = 32;

    // One level per operation opcode
    localparam int op_num = 6;

    // Codes 2, 4, 7, 9 and 15 have no opcode
    typedef enum logic [3:0] {
        op_itoa     = 4'd0,
        op_itow     = 4'd1,
        op_atow     = 4'd3,
        op_conv     = 4'd5,
        op_pool     = 4'd6,
        op_read     = 4'd8,
        op_inf_mult = 4'd10,
        op_inf_bias = 4'd11,
        op_inf_conv = 4'd12,
        op_inf_aram = 4'd13,
        op_inf_wram = 4'd14
    } opcode_t;

    //======================================================================
    // Command field map, lsb and width of each field
    //======================================================================
    localparam int fld_opcode_lo    = 0,  fld_opcode_w    = 4;
    // RAM windows and bank indexes
    localparam int fld_aram_len_lo  = 4,  fld_aram_len_w  = 12;
    localparam int fld_aram_idx_lo  = 16, fld_aram_idx_w  = 4;
    localparam int fld_aram_add_lo  = 20, fld_aram_add_w  = 12;
    localparam int fld_wram_len_lo  = 4,  fld_wram_len_w  = 13;
    localparam int fld_wram_sel_lo  = 17, fld_wram_sel_w  = 2;
    localparam int fld_wram_add_lo  = 19, fld_wram_add_w  = 13;
    localparam int fld_wram_idx_lo  = 12, fld_wram_idx_w  = 4;
    localparam int fld_oram_idx_lo  = 8,  fld_oram_idx_w  = 4;
    // Layer shape and coefficient base
    localparam int fld_conv_ich_lo  = 4,  fld_conv_ich_w  = 8;
    localparam int fld_conv_och_lo  = 12, fld_conv_och_w  = 8;
    localparam int fld_conv_len_lo  = 20, fld_conv_len_w  = 10;
    localparam int fld_coef_add_lo  = 4,  fld_coef_add_w  = 13;
    // CONV settings
    localparam int fld_strd_lo      = 4,  fld_strd_w      = 2;
    localparam int fld_dila_lo      = 6,  fld_dila_w      = 2;
    localparam int fld_wei_lo       = 8,  fld_wei_w       = 3;
    localparam int fld_resn_lo      = 11, fld_resn_w      = 1;
    localparam int fld_cpad_lo      = 15, fld_cpad_w      = 1;
    localparam int fld_relu_conv_lo = 16, fld_relu_conv_w = 1;
    // POOL settings
    localparam int fld_relu_pool_lo = 18, fld_relu_pool_w = 1;
    localparam int fld_maxp_lo      = 16, fld_maxp_w      = 1;
    localparam int fld_avgp_lo      = 17, fld_avgp_w      = 1;
    localparam int fld_pool_fac_lo  = 4,  fld_pool_fac_w  = 2;
    localparam int fld_pool_len_lo  = 22, fld_pool_len_w  = 10;

endpackage

`default_nettype wire

// File: eeg_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeg_cmd_top
    import eeg_cmd_pkg::*, eeg_cfg_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cmd_vld,
    input  wire  [cmd_w-1:0]      cmd_dat,
    output logic                  info_vld,
    output logic [op_num-1:0]     info_cmd,
    output logic [op_num-1:0]     op_lvl,
    // RAM windows
    output logic [bank_w-1:0]     aram_idx,
    output logic [bank_w-1:0]     wram_idx,
    output logic [bank_w-1:0]     oram_idx,
    output logic [aram_add_w-1:0] aram_add,
    output logic [aram_add_w-1:0] aram_len,
    output logic [wram_add_w-1:0] wram_add,
    output logic [wram_add_w-1:0] wram_len,
    // Convolution
    output logic [conv_ch_w-1:0]  conv_ich,
    output logic [conv_ch_w-1:0]  conv_och,
    output logic [conv_len_w-1:0] conv_len,
    output logic [wram_add_w-1:0] mult_add,
    output logic [wram_add_w-1:0] bias_add,
    output logic [fac_w-1:0]      strd_fac,
    output logic [fac_w-1:0]      dila_fac,
    output logic [wei_w-1:0]      conv_wei,
    output logic                  resn_ena,
    output logic                  cpad_ena,
    // Pooling
    output logic [pool_len_w-1:0] pool_len,
    output logic [fac_w-1:0]      pool_fac,
    output logic                  maxp_ena,
    output logic                  avgp_ena,
    output logic                  relu_ena
);

    // Decoder strobes into the banks
    logic aram_idx_ld;
    logic wram_idx_ld;
    logic wram_sel_ld;
    logic oram_idx_ld;
    logic aram_win_ld;
    logic wram_win_ld;
    logic layer_ld;
    logic mult_ld;
    logic bias_ld;
    logic conv_ld;
    logic pool_ld;

    //======================================================================
    // Opcode decode
    //======================================================================
    cmd_decoder u_dec (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_vld     (cmd_vld),
        .cmd_dat     (cmd_dat),
        .aram_idx_ld (aram_idx_ld),
        .wram_idx_ld (wram_idx_ld),
        .wram_sel_ld (wram_sel_ld),
        .oram_idx_ld (oram_idx_ld),
        .aram_win_ld (aram_win_ld),
        .wram_win_ld (wram_win_ld),
        .layer_ld    (layer_ld),
        .mult_ld     (mult_ld),
        .bias_ld     (bias_ld),
        .conv_ld     (conv_ld),
        .pool_ld     (pool_ld),
        .op_lvl      (op_lvl),
        .info_vld    (info_vld),
        .info_cmd    (info_cmd)
    );

    //======================================================================
    // Configuration banks
    //======================================================================
    ram_cfg_regs u_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_dat     (cmd_dat),
        .aram_idx_ld (aram_idx_ld),
        .wram_idx_ld (wram_idx_ld),
        .wram_sel_ld (wram_sel_ld),
        .oram_idx_ld (oram_idx_ld),
        .aram_win_ld (aram_win_ld),
        .wram_win_ld (wram_win_ld),
        .aram_idx    (aram_idx),
        .wram_idx    (wram_idx),
        .oram_idx    (oram_idx),
        .aram_add    (aram_add),
        .aram_len    (aram_len),
        .wram_add    (wram_add),
        .wram_len    (wram_len)
    );

    conv_cfg_regs u_conv (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_dat  (cmd_dat),
        .layer_ld (layer_ld),
        .mult_ld  (mult_ld),
        .bias_ld  (bias_ld),
        .conv_ld  (conv_ld),
        .conv_ich (conv_ich),
        .conv_och (conv_och),
        .conv_len (conv_len),
        .mult_add (mult_add),
        .bias_add (bias_add),
        .strd_fac (strd_fac),
        .dila_fac (dila_fac),
        .conv_wei (conv_wei),
        .resn_ena (resn_ena),
        .cpad_ena (cpad_ena)
    );

    // CONV also reaches this bank for the shared ReLU enable
    pool_cfg_regs u_pool (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_dat  (cmd_dat),
        .conv_ld  (conv_ld),
        .pool_ld  (pool_ld),
        .pool_len (pool_len),
        .pool_fac (pool_fac),
        .maxp_ena (maxp_ena),
        .avgp_ena (avgp_ena),
        .relu_ena (relu_ena)
    );

endmodule

`default_nettype wire

// File: pool_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pool_cfg_regs
    import eeg_cmd_pkg::*, eeg_cfg_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire  [cmd_w-1:0]      cmd_dat,
    input  wire                   conv_ld,
    input  wire                   pool_ld,
    output logic [pool_len_w-1:0] pool_len,
    output logic [fac_w-1:0]      pool_fac,
    output logic                  maxp_ena,
    output logic                  avgp_ena,
    output logic                  relu_ena
);

    // Pooling window settings
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pool_len <= '0;
            pool_fac <= '0;
            maxp_ena <= 1'b0;
            avgp_ena <= 1'b0;
        end else if (pool_ld) begin
            pool_len <= cmd_dat[fld_pool_len_lo +: fld_pool_len_w];
            pool_fac <= cmd_dat[fld_pool_fac_lo +: fld_pool_fac_w];
            maxp_ena <= cmd_dat[fld_maxp_lo +: fld_maxp_w];
            avgp_ena <= cmd_dat[fld_avgp_lo +: fld_avgp_w];
        end
    end

    //======================================================================
    // ReLU enable, shared by CONV and POOL
    //======================================================================
    // Last writer wins, each from its own bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            relu_ena <= 1'b0;
        end else if (conv_ld) begin
            relu_ena <= cmd_dat[fld_relu_conv_lo +: fld_relu_conv_w];
        end else if (pool_ld) begin
            relu_ena <= cmd_dat[fld_relu_pool_lo +: fld_relu_pool_w];
        end
    end

endmodule

`default_nettype wire

// File: project.f
eeg_cmd_pkg.sv
eeg_cfg_pkg.sv
cmd_decoder.sv
ram_cfg_regs.sv
conv_cfg_regs.sv
pool_cfg_regs.sv
eeg_cmd_top.sv
eeg_cmd_checker.sv
tb_eeg_cmd.sv

// File: ram_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ram_cfg_regs
    import eeg_cmd_pkg::*, eeg_cfg_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire  [cmd_w-1:0]      cmd_dat,
    input  wire                   aram_idx_ld,
    input  wire                   wram_idx_ld,
    input  wire                   wram_sel_ld,
    input  wire                   oram_idx_ld,
    input  wire                   aram_win_ld,
    input  wire                   wram_win_ld,
    output logic [bank_w-1:0]     aram_idx,
    output logic [bank_w-1:0]     wram_idx,
    output logic [bank_w-1:0]     oram_idx,
    output logic [aram_add_w-1:0] aram_add,
    output logic [aram_add_w-1:0] aram_len,
    output logic [wram_add_w-1:0] wram_add,
    output logic [wram_add_w-1:0] wram_len
);

    // Select value n picks weight bank n
    logic [bank_w-1:0] sel_hot;

    assign sel_hot = bank_w'(1) << cmd_dat[fld_wram_sel_lo +: fld_wram_sel_w];

    //======================================================================
    // Bank indexes
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aram_idx <= '0;
        end else if (aram_idx_ld) begin
            aram_idx <= cmd_dat[fld_aram_idx_lo +: fld_aram_idx_w];
        end
    end

    // ITOW selects one bank, ATOW and READ give the mask directly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wram_idx <= '0;
        end else if (wram_sel_ld) begin
            wram_idx <= sel_hot;
        end else if (wram_idx_ld) begin
            wram_idx <= cmd_dat[fld_wram_idx_lo +: fld_wram_idx_w];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            oram_idx <= '0;
        end else if (oram_idx_ld) begin
            oram_idx <= cmd_dat[fld_oram_idx_lo +: fld_oram_idx_w];
        end
    end

    //======================================================================
    // RAM windows
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aram_add <= '0;
            aram_len <= '0;
        end else if (aram_win_ld) begin
            aram_add <= cmd_dat[fld_aram_add_lo +: fld_aram_add_w];
            aram_len <= cmd_dat[fld_aram_len_lo +: fld_aram_len_w];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wram_add <= '0;
            wram_len <= '0;
        end else if (wram_win_ld) begin
            wram_add <= cmd_dat[fld_wram_add_lo +: fld_wram_add_w];
            wram_len <= cmd_dat[fld_wram_len_lo +: fld_wram_len_w];
        end
    end

endmodule

`default_nettype wire

// File: tb_eeg_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeg_cmd
    import eeg_cmd_pkg::*, eeg_cfg_pkg::*;
;

    localparam int n_rnd = 40;

    logic                  clk;
    logic                  rst_n;
    logic                  cmd_vld;
    logic [cmd_w-1:0]      cmd_dat;
    logic                  info_vld;
    logic [op_num-1:0]     info_cmd;
    logic [op_num-1:0]     op_lvl;
    logic [bank_w-1:0]     aram_idx;
    logic [bank_w-1:0]     wram_idx;
    logic [bank_w-1:0]     oram_idx;
    logic [aram_add_w-1:0] aram_add;
    logic [aram_add_w-1:0] aram_len;
    logic [wram_add_w-1:0] wram_add;
    logic [wram_add_w-1:0] wram_len;
    logic [conv_ch_w-1:0]  conv_ich;
    logic [conv_ch_w-1:0]  conv_och;
    logic [conv_len_w-1:0] conv_len;
    logic [wram_add_w-1:0] mult_add;
    logic [wram_add_w-1:0] bias_add;
    logic [fac_w-1:0]      strd_fac;
    logic [fac_w-1:0]      dila_fac;
    logic [wei_w-1:0]      conv_wei;
    logic                  resn_ena;
    logic                  cpad_ena;
    logic [pool_len_w-1:0] pool_len;
    logic [fac_w-1:0]      pool_fac;
    logic                  maxp_ena;
    logic                  avgp_ena;
    logic                  relu_ena;

    // Reference model, a shadow of every register
    logic [op_num-1:0]     m_op = '0;
    logic [bank_w-1:0]     m_aram_idx = '0, m_wram_idx = '0, m_oram_idx = '0;
    logic [aram_add_w-1:0] m_aram_add = '0, m_aram_len = '0;
    logic [wram_add_w-1:0] m_wram_add = '0, m_wram_len = '0, m_mult_add = '0, m_bias_add = '0;
    logic [conv_ch_w-1:0]  m_conv_ich = '0, m_conv_och = '0;
    logic [conv_len_w-1:0] m_conv_len = '0;
    logic [pool_len_w-1:0] m_pool_len = '0;
    logic [fac_w-1:0]      m_strd_fac = '0, m_dila_fac = '0, m_pool_fac = '0;
    logic [wei_w-1:0]      m_conv_wei = '0;
    logic                  m_resn = 1'b0, m_cpad = 1'b0, m_maxp = 1'b0, m_avgp = 1'b0;
    logic                  m_relu = 1'b0;

    // Stimulus table
    string             tab_name[$];
    logic [cmd_w-1:0]  tab_cmd[$];
    int                tab_gap[$];
    logic [op_num-1:0] tab_op[$];
    bit                tab_ready = 1'b0;

    integer seed = 52;
    int     chk_cnt = 0;
    int     err_cnt = 0;

    eeg_cmd_top DUT (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    //======================================================================
    // Compare tasks
    //======================================================================
    task automatic compare_word(input string t, input string s, input logic [31:0] e,
                                input logic [31:0] a, input bit ok);
        chk_cnt++;
        if (!ok) begin
            err_cnt++;
            $display("ERROR %s: %s expected %0h, actual %0h", t, s, e, a);
        end
    endtask

    task automatic check_flag(input string t, input string s, input logic e, a);
        compare_word(t, s, 32'(e), 32'(a), a === e);
    endtask

    task automatic check_bank(input string t, input string s, input logic [bank_w-1:0] e, a);
        compare_word(t, s, 32'(e), 32'(a), a === e);
    endtask

    task automatic check_aram(input string t, input string s, input logic [aram_add_w-1:0] e, a);
        compare_word(t, s, 32'(e), 32'(a), a === e);
    endtask

    task automatic check_wram(input string t, input string s, input logic [wram_add_w-1:0] e, a);
        compare_word(t, s, 32'(e), 32'(a), a === e);
    endtask

    task automatic check_chan(input string t, input string s, input logic [conv_ch_w-1:0] e, a);
        compare_word(t, s, 32'(e), 32'(a), a === e);
    endtask

    task automatic check_len(input string t, input string s, input logic [conv_len_w-1:0] e, a);
        compare_word(t, s, 32'(e), 32'(a), a === e);
    endtask

    task automatic check_fac(input string t, input string s, input logic [fac_w-1:0] e, a);
        compare_word(t, s, 32'(e), 32'(a), a === e);
    endtask

    task automatic check_wei(input string t, input string s, input logic [wei_w-1:0] e, a);
        compare_word(t, s, 32'(e), 32'(a), a === e);
    endtask

    task automatic check_op(input string t, input string s, input logic [op_num-1:0] e, a);
        compare_word(t, s, 32'(e), 32'(a), a === e);
    endtask

    task automatic check_all(input string t, input logic e_vld, input logic [op_num-1:0] e_op);
        check_flag(t, "info_vld", e_vld, info_vld);
        check_op(t, "op_lvl", e_op, op_lvl);
        check_op(t, "info_cmd", e_op, info_cmd);
        check_bank(t, "aram_idx", m_aram_idx, aram_idx);
        check_bank(t, "wram_idx", m_wram_idx, wram_idx);
        check_bank(t, "oram_idx", m_oram_idx, oram_idx);
        check_aram(t, "aram_add", m_aram_add, aram_add);
        check_aram(t, "aram_len", m_aram_len, aram_len);
        check_wram(t, "wram_add", m_wram_add, wram_add);
        check_wram(t, "wram_len", m_wram_len, wram_len);
        check_wram(t, "mult_add", m_mult_add, mult_add);
        check_wram(t, "bias_add", m_bias_add, bias_add);
        check_chan(t, "conv_ich", m_conv_ich, conv_ich);
        check_chan(t, "conv_och", m_conv_och, conv_och);
        check_len(t, "conv_len", m_conv_len, conv_len);
        check_len(t, "pool_len", m_pool_len, pool_len);
        check_fac(t, "strd_fac", m_strd_fac, strd_fac);
        check_fac(t, "dila_fac", m_dila_fac, dila_fac);
        check_fac(t, "pool_fac", m_pool_fac, pool_fac);
        check_wei(t, "conv_wei", m_conv_wei, conv_wei);
        check_flag(t, "resn_ena", m_resn, resn_ena);
        check_flag(t, "cpad_ena", m_cpad, cpad_ena);
        check_flag(t, "maxp_ena", m_maxp, maxp_ena);
        check_flag(t, "avgp_ena", m_avgp, avgp_ena);
        check_flag(t, "relu_ena", m_relu, relu_ena);
    endtask

    //======================================================================
    // Reference model, from the command field map
    //======================================================================
    task automatic model_update(input logic [cmd_w-1:0] c);
        m_op = '0;
        case (c[3:0])
            op_itoa: begin
                m_aram_add = c[31:20];
                m_aram_len = c[15:4];
                m_aram_idx = c[19:16];
                m_op       = 6'b000001;
            end
            op_itow: begin
                m_wram_add = c[31:19];
                m_wram_len = c[16:4];
                case (c[18:17])
                    2'd0:    m_wram_idx = 4'b0001;
                    2'd1:    m_wram_idx = 4'b0010;
                    2'd2:    m_wram_idx = 4'b0100;
                    default: m_wram_idx = 4'b1000;
                endcase
                m_op = 6'b000010;
            end
            op_atow: begin
                m_wram_idx = c[15:12];
                m_aram_idx = c[19:16];
                m_op       = 6'b000100;
            end
            op_conv: begin
                m_strd_fac = c[5:4];
                m_dila_fac = c[7:6];
                m_conv_wei = c[10:8];
                m_resn     = c[11];
                m_cpad     = c[15];
                m_relu     = c[16];
                m_op       = 6'b001000;
            end
            op_pool: begin
                m_pool_fac = c[5:4];
                m_maxp     = c[16];
                m_avgp     = c[17];
                m_relu     = c[18];
                m_pool_len = c[31:22];
                m_op       = 6'b010000;
            end
            op_read: begin
                m_oram_idx = c[11:8];
                m_wram_idx = c[15:12];
                m_aram_idx = c[19:16];
                m_op       = 6'b100000;
            end
            op_inf_mult: m_mult_add = c[16:4];
            op_inf_bias: m_bias_add = c[16:4];
            op_inf_conv: begin
                m_conv_ich = c[11:4];
                m_conv_och = c[19:12];
                m_conv_len = c[29:20];
            end
            op_inf_aram: begin
                m_aram_add = c[31:20];
                m_aram_len = c[15:4];
            end
            op_inf_wram: begin
                m_wram_add = c[31:19];
                m_wram_len = c[16:4];
            end
            default: ;
        endcase
    endtask

    task automatic add_entry(input string nm, input logic [cmd_w-1:0] c, input int gap,
                             input logic [op_num-1:0] op);
        tab_name.push_back(nm);
        tab_cmd.push_back(c);
        tab_gap.push_back(gap);
        tab_op.push_back(op);
    endtask

    // Name, command word, idle cycles after it, expected op levels
    task automatic fill_table();
        add_entry("itoa",            32'hABC5_1230, 1, 6'b000001);
        add_entry("inf_aram",        32'h456F_789D, 0, 6'b000000);
        add_entry("itow_sel0",       32'hD5E0_F0F1, 0, 6'b000010);
        add_entry("itow_sel1",       32'h000B_FFF1, 0, 6'b000010);
        add_entry("itow_sel2",       32'h0004_0001, 0, 6'b000010);
        add_entry("itow_sel3",       32'hFFFE_0011, 1, 6'b000010);
        add_entry("inf_wram",        32'h5550_555E, 0, 6'b000000);
        add_entry("atow",            32'h9876_A543, 1, 6'b000100);
        add_entry("read",            32'h1239_3C78, 2, 6'b100000);
        add_entry("inf_conv",        32'h3E82_040C, 0, 6'b000000);
        add_entry("inf_mult",        32'h0001_234A, 0, 6'b000000);
        add_entry("inf_bias",        32'h0000_ABCB, 0, 6'b000000);
        add_entry("conv",            32'h0001_8D65, 1, 6'b001000);
        add_entry("unused_7",        32'hFFFF_FFF7, 0, 6'b000000);
        add_entry("itoa_after_conv", 32'h0010_0010, 0, 6'b000001);
        add_entry("pool",            32'hAA81_0036, 1, 6'b010000);
        add_entry("conv_relu",       32'h0001_0005, 0, 6'b001000);
        add_entry("pool_relu",       32'h5546_0016, 1, 6'b010000);
        add_entry("unused_2",        32'h0000_0002, 0, 6'b000000);
        add_entry("unused_4",        32'h1234_5674, 0, 6'b000000);
        add_entry("unused_9",        32'h0000_0009, 0, 6'b000000);
        add_entry("unused_15",       32'hFFFF_FFFF, 1, 6'b000000);
    endtask

    // Command for one cycle, then idle cycles with junk data on the bus
    task automatic apply_cmd(input string nm, input logic [cmd_w-1:0] c, input int gap,
                             input logic [op_num-1:0] op, input bit from_tab);
        cmd_vld = 1'b1;
        cmd_dat = c;
        model_update(c);
        @(posedge clk);
        #1;
        check_all(nm, 1'b1, from_tab ? op : m_op);
        cmd_vld = 1'b0;
        cmd_dat = $random(seed);
        repeat (gap) begin
            @(posedge clk);
            #1;
            check_all(nm, 1'b0, m_op);
        end
    endtask

    //======================================================================
    // Main sequence
    //======================================================================
    initial begin
        rst_n   = 1'b0;
        cmd_vld = 1'b0;
        cmd_dat = '0;
        fill_table();
        tab_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_all("reset", 1'b0, '0);

        foreach (tab_cmd[i]) begin
            apply_cmd(tab_name[i], tab_cmd[i], tab_gap[i], tab_op[i], 1'b1);
        end

        // Back to back random words over all sixteen codes
        for (int k = 0; k < n_rnd; k++) begin
            apply_cmd($sformatf("random_%0d", k), $random(seed), 0, '0, 1'b0);
        end

        @(posedge clk);
        #1;
        check_all("idle", 1'b0, m_op);
        repeat (2) @(posedge clk);

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 chk_cnt, err_cnt, DUT.u_dec.u_chk.fail_cnt);
        if (err_cnt == 0 && DUT.u_dec.u_chk.fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog, four cycles per command plus margin
    initial begin
        int limit;
        wait (tab_ready);
        limit = (tab_cmd.size() + n_rnd) * 4 + 50;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
